// File: source/prbs_pkg.sv
// generator side definitions, shared by generator and checker
package prbs_pkg;

    // lfsr state width, wide enough for the longest preset
    localparam int PRBS_W = 32;

    // tap masks, newest bit at position 0
    // prbs7: x^7 + x^6 + 1
    localparam logic [PRBS_W-1:0] POLY_PRBS7 = 32'h0000_0060;
    // prbs15: x^15 + x^14 + 1
    localparam logic [PRBS_W-1:0] POLY_PRBS15 = 32'h0000_6000;
    // prbs31: x^31 + x^28 + 1
    localparam logic [PRBS_W-1:0] POLY_PRBS31 = 32'h4800_0000;

    // bit positions inside inv
    localparam int INV_FB = 0;
    localparam int INV_OUT = 1;

    // static link configuration
    typedef struct packed {
        // tap mask
        logic [PRBS_W-1:0] eqn;
        // seed, loaded during reset
        logic [PRBS_W-1:0] init_val;
        // bit 0 flips feedback, bit 1 flips the line bit
        logic [1:0] inv;
    } prbs_cfg_t;

endpackage

// File: source/chk_pkg.sv
// checker limits and status
package chk_pkg;

    // saturating error counter width
    localparam int ERR_CNT_W = 16;

    // consecutive matches before lock
    localparam int LOCK_RUN = 64;
    // consecutive mismatches that drop lock
    localparam int LOSS_RUN = 8;

    // run counter widths, counting up to limit minus one
    localparam int LOCK_CNT_W = $clog2(LOCK_RUN);
    localparam int LOSS_CNT_W = $clog2(LOSS_RUN);

    // checker status as seen at the top level
    typedef struct packed {
        logic locked;
        // one enabled cycle per counted error
        logic err_pulse;
        logic [ERR_CNT_W-1:0] err_count;
    } chk_status_t;

endpackage

// File: source/prbs_generator.sv
`default_nettype none

// fibonacci lfsr pattern source with single-bit error injection
module prbs_generator (
    input wire logic clk,
    input wire logic rst,

    // common clock enable, all state holds while low
    input wire logic cke,

    // tap mask, seed and inversion bits
    input wire prbs_pkg::prbs_cfg_t cfg,

    // level, each rising edge gives one flipped bit
    input wire logic inj_err,

    // line bit
    output logic tx
);
    import prbs_pkg::*;

    // sampled inj_err, newest at bit 0
    logic [3:0] inj_hist;
    // one enabled cycle wide, two stages after the edge is seen
    logic inj_pulse;

    // last PRBS_W sequence bits, newest at bit 0
    logic [PRBS_W-1:0] state;
    // next sequence bit
    logic fb_bit;

    // inj_err history
    always_ff @(posedge clk) begin
        if (rst) begin
            inj_hist <= '0;
        end else if (cke) begin
            inj_hist <= {inj_hist[2:0], inj_err};
        end
    end

    // rising edge seen two stages down
    // lands on tx three enabled edges after first sample
    assign inj_pulse = inj_hist[2] & ~inj_hist[3];

    // parity of tapped bits, then optional feedback inversion
    assign fb_bit = (^(state & cfg.eqn)) ^ cfg.inv[INV_FB];

    // lfsr, seeded while in reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cfg.init_val;
        end else if (cke) begin
            state <= {state[PRBS_W-2:0], fb_bit};
        end
    end

    // output register
    // oldest bit leaves, injection and line inversion applied here
    always_ff @(posedge clk) begin
        if (rst) begin
            tx <= 1'b0;
        end else if (cke) begin
            tx <= state[PRBS_W-1] ^ inj_pulse ^ cfg.inv[INV_OUT];
        end
    end

endmodule

`default_nettype wire

// File: source/prbs_checker.sv
`default_nettype none

// self-synchronizing prbs checker
// hunts on received bits, then free-runs on its own prediction once locked
module prbs_checker (
    input wire logic clk,
    input wire logic rst,

    // common clock enable
    input wire logic cke,

    // same configuration as the generator, seed unused here
    input wire prbs_pkg::prbs_cfg_t cfg,

    // returning line bit
    input wire logic rx,

    // clears err_count on the next edge, cke ignored
    input wire logic clr_count,

    output chk_pkg::chk_status_t status
);
    import prbs_pkg::*;
    import chk_pkg::*;

    // received bit with line inversion stripped
    logic rx_bit;
    // expected bit from history
    logic pred_bit;
    logic mismatch;

    // newest bit at position 0
    logic [PRBS_W-1:0] hist;

    // lock fsm state
    logic locked_q;
    // matches in a row while hunting
    logic [LOCK_CNT_W-1:0] match_run;
    // mismatches in a row while locked
    logic [LOSS_CNT_W-1:0] miss_run;

    // error reporting
    logic err_pulse_q;
    logic [ERR_CNT_W-1:0] err_cnt_q;

    assign rx_bit = rx ^ cfg.inv[INV_OUT];

    // same recurrence as the generator feedback
    assign pred_bit = (^(hist & cfg.eqn)) ^ cfg.inv[INV_FB];
    assign mismatch = rx_bit != pred_bit;

    // history
    // received bits while hunting, predicted bits once locked
    // so a single line error costs one mismatch, not one per tap
    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
        end else if (cke) begin
            hist <= {hist[PRBS_W-2:0], locked_q ? pred_bit : rx_bit};
        end
    end

    // hunt / locked transitions
    always_ff @(posedge clk) begin
        if (rst) begin
            locked_q  <= 1'b0;
            match_run <= '0;
            miss_run  <= '0;
        end else if (cke) begin
            if (!locked_q) begin
                miss_run <= '0;
                if (mismatch) begin
                    match_run <= '0;
                end else if (match_run == LOCK_CNT_W'(LOCK_RUN - 1)) begin
                    // LOCK_RUN-th match in a row
                    locked_q  <= 1'b1;
                    match_run <= '0;
                end else begin
                    match_run <= match_run + 1'b1;
                end
            end else begin
                match_run <= '0;
                if (!mismatch) begin
                    miss_run <= '0;
                end else if (miss_run == LOSS_CNT_W'(LOSS_RUN - 1)) begin
                    // stream lost, back to hunting
                    locked_q <= 1'b0;
                    miss_run <= '0;
                end else begin
                    miss_run <= miss_run + 1'b1;
                end
            end
        end
    end

    // error strobe, same edge as the count
    always_ff @(posedge clk) begin
        if (rst) begin
            err_pulse_q <= 1'b0;
        end else if (cke) begin
            err_pulse_q <= locked_q & mismatch;
        end
    end

    // saturating error counter
    always_ff @(posedge clk) begin
        if (rst) begin
            err_cnt_q <= '0;
        end else if (clr_count) begin
            err_cnt_q <= '0;
        end else if (cke && locked_q && mismatch && (err_cnt_q != '1)) begin
            err_cnt_q <= err_cnt_q + 1'b1;
        end
    end

    assign status = '{locked: locked_q, err_pulse: err_pulse_q, err_count: err_cnt_q};

endmodule

`default_nettype wire

// File: source/prbs_link_top.sv
`default_nettype none

// prbs link test block
// tx and rx are separate, the loop is closed outside
module prbs_link_top (
    input wire logic clk,
    input wire logic rst,

    // common clock enable for both sides
    input wire logic cke,

    // static, must not change outside reset
    input wire prbs_pkg::prbs_cfg_t cfg,

    // error injection level, edge triggered inside
    input wire logic inj_err,

    // returning bit
    input wire logic rx,

    // one-cycle strobe
    input wire logic clr_count,

    // outgoing bit
    output wire logic tx,

    output wire chk_pkg::chk_status_t status
);

    // pattern source
    prbs_generator u_gen (
        .clk     (clk),
        .rst     (rst),
        .cke     (cke),
        .cfg     (cfg),
        .inj_err (inj_err),
        .tx      (tx)
    );

    // pattern checker, same polynomial and inversion
    prbs_checker u_chk (
        .clk       (clk),
        .rst       (rst),
        .cke       (cke),
        .cfg       (cfg),
        .rx        (rx),
        .clr_count (clr_count),
        .status    (status)
    );

endmodule

`default_nettype wire

// File: verif/prbs_tb_tasks.svh
`ifndef PRBS_TB_TASKS_SVH
`define PRBS_TB_TASKS_SVH

// fibonacci lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
function logic rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
endfunction

function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], rand_bit()};
    end
    return r;
endfunction

// reference recurrence shifting the oldest bit out and the tap parity in
function logic model_next();
    logic out_bit;
    logic fb;
    out_bit = model_state[PRBS_W-1] ^ cfg.inv[1];
    fb = (^(model_state & cfg.eqn)) ^ cfg.inv[0];
    model_state = {model_state[PRBS_W-2:0], fb};
    return out_bit;
endfunction

task report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
    errors++;
endtask

task report_failure(input string what);
    $display("FAILED: %s at %0t", what, $time);
    errors++;
endtask

task finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
        tests_passed++;
        $display("%s: pass", name);
    end else begin
        tests_failed++;
        $display("%s: FAIL with %0d errors", name, errors - errs_before);
    end
endtask

// one clock with the model following enabled edges
task tick();
    logic en;
    en = cke;
    @(posedge clk);
    #1;
    if (en) begin
        exp_tx = model_next();
    end
endtask

// cfg may only change here
task apply_reset(input prbs_cfg_t c);
    rst = 1'b1;
    cfg = c;
    cke = 1'b1;
    flip = 1'b0;
    inj_err = 1'b0;
    clr_count = 1'b0;
    repeat (5) begin
        @(posedge clk);
        #1;
    end
    rst = 1'b0;
    model_state = c.init_val;
endtask

// enabled edges until locked or past the bound
task wait_lock();
    int edges;
    edges = 0;
    while (!status.locked && edges < LOCK_RUN + 2 * PRBS_W) begin
        tick();
        edges++;
    end
    if (!status.locked) begin
        report_failure("checker did not lock within bound");
    end
endtask

task test_sequence();
    logic [PRBS_W-1:0] polys [3];
    prbs_cfg_t c;
    int e0;
    e0 = errors;
    polys = '{POLY_PRBS7, POLY_PRBS15, POLY_PRBS31};
    for (int p = 0; p < 3; p++) begin
        for (int iv = 0; iv < 4; iv++) begin
            c = '{eqn: polys[p], init_val: 32'h1357_9bdf, inv: 2'(iv)};
            apply_reset(c);
            for (int k = 0; k < 200; k++) begin
                tick();
                if (tx !== exp_tx) begin
                    report_mismatch("tx", 32'(exp_tx), 32'(tx));
                end
            end
        end
    end
    finish_test("sequence", e0);
endtask

task test_clock_enable();
    logic prev_tx;
    chk_status_t prev_st;
    logic en;
    int e0;
    e0 = errors;
    apply_reset('{eqn: POLY_PRBS15, init_val: 32'h0bad_cafe, inv: 2'b01});
    for (int k = 0; k < 300; k++) begin
        en = rand_bit();
        cke = en;
        prev_tx = tx;
        prev_st = status;
        tick();
        if (!en && tx !== prev_tx) begin
            report_mismatch("tx", 32'(prev_tx), 32'(tx));
        end
        if (!en && status !== prev_st) begin
            report_mismatch("status", 32'(prev_st), 32'(status));
        end
        if (en && tx !== exp_tx) begin
            report_mismatch("tx", 32'(exp_tx), 32'(tx));
        end
    end
    cke = 1'b1;
    finish_test("clock_enable", e0);
endtask

task test_lock();
    int e0;
    e0 = errors;
    apply_reset('{eqn: POLY_PRBS31, init_val: 32'h7654_3210, inv: 2'b10});
    wait_lock();
    for (int k = 0; k < 200; k++) begin
        tick();
        if (!status.locked) begin
            report_failure("lock dropped on a clean loopback");
        end
    end
    if (status.err_count !== '0) begin
        report_mismatch("err_count", 32'h0, 32'(status.err_count));
    end
    finish_test("lock", e0);
endtask

task test_injection();
    int e0;
    e0 = errors;
    apply_reset('{eqn: POLY_PRBS7, init_val: 32'h0000_0041, inv: 2'b00});
    wait_lock();
    // four short pulses and then one long level
    for (int n = 0; n < 5; n++) begin
        inj_err = 1'b1;
        for (int k = 1; k <= 40; k++) begin
            tick();
            // edge 1 samples the level and the flip shows on edge 4
            if (tx !== (exp_tx ^ (k == 4))) begin
                report_mismatch("tx", 32'(exp_tx ^ (k == 4)), 32'(tx));
            end
            // checker sees the flipped bit one edge later
            if (status.err_pulse !== (k == 5)) begin
                report_mismatch("err_pulse", 32'(k == 5), 32'(status.err_pulse));
            end
            if (n < 4 || k == 30) begin
                inj_err = 1'b0;
            end
        end
    end
    repeat (3) tick();
    if (status.err_count !== 16'd5) begin
        report_mismatch("err_count", 32'd5, 32'(status.err_count));
    end
    finish_test("injection", e0);
endtask

task test_channel_errors();
    int nflips;
    int run_len;
    int total;
    int e0;
    e0 = errors;
    total = 0;
    apply_reset('{eqn: POLY_PRBS15, init_val: 32'h00c0_ffee, inv: 2'b11});
    wait_lock();
    nflips = 3 + int'(rand_bits(3));
    for (int n = 0; n < nflips; n++) begin
        repeat (40 + int'(rand_bits(5))) tick();
        // short bursts always below the loss run
        run_len = 1 + int'(rand_bits(2));
        flip = 1'b1;
        repeat (run_len) tick();
        flip = 1'b0;
        total += run_len;
    end
    repeat (4) tick();
    if (!status.locked) begin
        report_failure("lock lost on isolated channel errors");
    end
    if (status.err_count !== 16'(total)) begin
        report_mismatch("err_count", 32'(total), 32'(status.err_count));
    end
    clr_count = 1'b1;
    tick();
    clr_count = 1'b0;
    if (status.err_count !== '0) begin
        report_mismatch("err_count", 32'h0, 32'(status.err_count));
    end
    finish_test("channel_errors", e0);
endtask

task test_lock_loss();
    int e0;
    e0 = errors;
    apply_reset('{eqn: POLY_PRBS31, init_val: 32'h2468_ace1, inv: 2'b00});
    wait_lock();
    flip = 1'b1;
    repeat (16) tick();
    if (status.locked) begin
        report_failure("lock held through an inverted channel");
    end
    flip = 1'b0;
    wait_lock();
    finish_test("lock_loss", e0);
endtask

`endif

// File: verif/prbs_link_tb.sv
module prbs_link_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import prbs_pkg::*;
    import chk_pkg::*;

    // rough sum of all test lengths in clock cycles
    localparam int TEST_CYCLES = 6000;
    localparam int CLK_PERIOD = 8;
    // twice the test length as headroom
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

    logic clk;
    logic rst;
    logic cke;
    prbs_cfg_t cfg;
    logic inj_err;
    logic rx;
    logic clr_count;
    logic tx;
    chk_status_t status;

    // channel corruption xored onto the loopback
    logic flip;

    // reference model state with the newest bit at 0
    logic [PRBS_W-1:0] model_state;
    // model bit for the last enabled edge
    logic exp_tx;

    // random source state
    logic [31:0] lfsr;

    int errors;
    int tests_passed;
    int tests_failed;

    prbs_link_top u_prbs_link_top (
        .clk       (clk),
        .rst       (rst),
        .cke       (cke),
        .cfg       (cfg),
        .inj_err   (inj_err),
        .rx        (rx),
        .clr_count (clr_count),
        .tx        (tx),
        .status    (status)
    );

    // loopback channel
    assign rx = tx ^ flip;

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "prbs_tb_tasks.svh"

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

    // test sequence
    initial begin
        rst = 1'b1;
        cke = 1'b1;
        cfg = '0;
        inj_err = 1'b0;
        clr_count = 1'b0;
        flip = 1'b0;
        model_state = '0;
        exp_tx = 1'b0;
        lfsr = 32'ha929;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;

        test_sequence();
        test_clock_enable();
        test_lock();
        test_injection();
        test_channel_errors();
        test_lock_loss();

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+verif
source/prbs_pkg.sv
source/chk_pkg.sv
source/prbs_generator.sv
source/prbs_checker.sv
source/prbs_link_top.sv
verif/prbs_link_tb.sv

// File: run.sh
#!/bin/sh
# build and run the PRBS link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module prbs_link_tb -o prbs_sim

out=$(./obj_dir/prbs_sim)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi
